// ==== Makefile ====
# Verilator build and run of the ICCM testbench

VERILATOR ?= verilator
TOP       ?= iccm_mem_tb
FILELIST  ?= iccm_mem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run, fails unless the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== iccm_bank_decode.sv ====
// Expects word-aligned writes and splatted lanes for word writes since even banks take lane 0
`timescale 1ns/1ps
`default_nettype none

module iccm_bank_decode (
   input  wire iccm_pkg::iccm_req_t                        req,
   output iccm_pkg::iccm_addr_t                            inc_addr,   // Second word of the pair
   output iccm_pkg::bank_req_t [iccm_pkg::NUM_BANKS-1:0]   bank_req
);

   logic [1:0]                     addr_incr;
   logic [iccm_pkg::NUM_BANKS-1:0] lo_hit;    // Bank of rw_addr
   logic [iccm_pkg::NUM_BANKS-1:0] hi_hit;    // Bank of inc_addr
   logic                           access;

   //*********************************************************************
   // Next address
   //*********************************************************************
   // Two halfwords on from a DW write, else one halfword
   assign addr_incr = iccm_pkg::is_dw(req.wr_size) ? 2'b10 : 2'b01;
   assign inc_addr  = req.rw_addr + iccm_pkg::iccm_addr_t'(addr_incr);

   assign lo_hit = iccm_pkg::bank_onehot(req.rw_addr);
   assign hi_hit = iccm_pkg::bank_onehot(inc_addr);
   assign access = req.wren | req.rden;

   //*********************************************************************
   // Per bank request
   //*********************************************************************
   for (genvar i = 0; i < iccm_pkg::NUM_BANKS; i++) begin : g_bank
      logic use_inc;

      // Row from inc_addr only when this bank is just the upper one
      // so a pair wrapping from bank 3 lands on the next row of bank 0
      assign use_inc = hi_hit[i] & ~lo_hit[i];

      assign bank_req[i].en    = access & (lo_hit[i] | hi_hit[i]);
      assign bank_req[i].we    = req.wren & (lo_hit[i] | hi_hit[i]);
      assign bank_req[i].index = use_inc ?
                                 inc_addr[iccm_pkg::INDEX_LO +: iccm_pkg::INDEX_BITS] :
                                 req.rw_addr[iccm_pkg::INDEX_LO +: iccm_pkg::INDEX_BITS];
      assign bank_req[i].wdata = req.wr_data[i % 2];   // Even banks lane 0, odd lane 1
   end

   //*********************************************************************
   // Checks
   //*********************************************************************
   // A DW write starting mid-word would split across three banks
   always_comb begin
      if (req.wren && iccm_pkg::is_dw(req.wr_size)) begin
         assert (!req.rw_addr[1])
            else $error("iccm_bank_decode DW write not word aligned");
      end
   end

endmodule

`default_nettype wire

// ==== iccm_bank_ram.sv ====
// Behavioural single port RAM with contents undefined until written and output held between reads
`timescale 1ns/1ps
`default_nettype none

module iccm_bank_ram (
   input  wire logic                 clk,
   input  wire iccm_pkg::bank_req_t  breq,
   output iccm_pkg::bank_word_t      dout    // Registered read word
);

   iccm_pkg::bank_word_t mem [(1<<iccm_pkg::INDEX_BITS)];

   //*********************************************************************
   // Array access
   //*********************************************************************
   always_ff @(posedge clk) begin
      if (breq.en) begin
         if (breq.we) begin
            mem[breq.index] <= breq.wdata;   // Write, read port untouched
         end
         else begin
            dout <= mem[breq.index];         // Read lands one cycle later
         end
      end
   end

endmodule

`default_nettype wire

// ==== iccm_mem.f ====
iccm_pkg.sv
iccm_bank_decode.sv
iccm_bank_ram.sv
iccm_redundancy.sv
iccm_read_align.sv
iccm_mem.sv
iccm_mem_checker.sv
iccm_mem_tb.sv

// ==== iccm_mem.sv ====
// Single clock ICCM with no back-pressure where reads return after one cycle and wren excludes rden
`timescale 1ns/1ps
`default_nettype none

module iccm_mem (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire iccm_pkg::iccm_req_t           req,
   input  wire logic                          buf_correct_ecc,   // Capture into a spare row
   output logic [2*iccm_pkg::DATA_W-1:0]      rd_data,
   output logic [2*iccm_pkg::WORD_W-1:0]      rd_data_ecc
);

   iccm_pkg::iccm_addr_t                            inc_addr;
   iccm_pkg::bank_req_t  [iccm_pkg::NUM_BANKS-1:0]  bank_req;
   iccm_pkg::bank_word_t [iccm_pkg::NUM_BANKS-1:0]  bank_dout;
   iccm_pkg::bank_word_t [iccm_pkg::NUM_BANKS-1:0]  dout_fn;

   //*********************************************************************
   // Request decode
   //*********************************************************************
   iccm_bank_decode u_decode (
      .req      (req),
      .inc_addr (inc_addr),
      .bank_req (bank_req)
   );

   //*********************************************************************
   // Banks
   //*********************************************************************
   for (genvar i = 0; i < iccm_pkg::NUM_BANKS; i++) begin : g_bank
      iccm_bank_ram u_ram (
         .clk  (clk),
         .breq (bank_req[i]),
         .dout (bank_dout[i])
      );
   end

   // Spare rows override faulty bank words
   iccm_redundancy u_red (
      .clk             (clk),
      .rst_n           (rst_n),
      .req             (req),
      .inc_addr        (inc_addr),
      .buf_correct_ecc (buf_correct_ecc),
      .bank_dout       (bank_dout),
      .dout_fn         (dout_fn)
   );

   iccm_read_align u_align (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .inc_addr    (inc_addr),
      .dout_fn     (dout_fn),
      .rd_data     (rd_data),
      .rd_data_ecc (rd_data_ecc)
   );

   // Banks have a single port
   a_rw_excl : assert property (@(posedge clk) disable iff (!rst_n)
      !(req.wren && req.rden))
      else $error("Read and write in the same cycle");

endmodule

`default_nettype wire

// ==== iccm_mem_checker.sv ====
// Model assumes reads use a word size code and captures arrive with rden low
`timescale 1ns/1ps
`default_nettype none

module iccm_mem_checker (
   input  wire logic                           clk,
   input  wire logic                           rst_n,
   input  wire iccm_pkg::iccm_req_t            req,
   input  wire logic                           buf_correct_ecc,
   input  wire logic [2*iccm_pkg::DATA_W-1:0]  rd_data,
   input  wire logic [2*iccm_pkg::WORD_W-1:0]  rd_data_ecc,
   input  wire logic [2:0]                     test_id,    // Running test
   input  wire logic                           test_end,   // One cycle pulse
   output int                                  checks,
   output int                                  errors
);

   iccm_pkg::bank_word_t ref_mem [iccm_pkg::NUM_BANKS << iccm_pkg::INDEX_BITS];
   logic [7:0]           row_addr [iccm_pkg::RED_ROWS];   // Word addresses
   iccm_pkg::bank_word_t row_data [iccm_pkg::RED_ROWS];
   logic                 row_valid [iccm_pkg::RED_ROWS];
   logic                 ref_lru;

   logic                              pend;        // Read waiting for its result
   logic [8:0]                        pend_addr;
   logic [2*iccm_pkg::DATA_W-1:0]     exp_data;
   logic [2*iccm_pkg::WORD_W-1:0]     exp_ecc;
   int                                test_checks;
   int                                test_errors;

   function automatic string test_label(input logic [2:0] id);
      case (id)
         3'd1:    return "word_write_read";
         3'd2:    return "double_word_write";
         3'd3:    return "odd_halfword_read";
         3'd4:    return "correction_capture";
         3'd5:    return "write_captured_word";
         default: return "none";
      endcase
   endfunction

   // Word as a read sees it with the spare copy over the bank copy
   function automatic iccm_pkg::bank_word_t fetch_word(input logic [7:0] w);
      iccm_pkg::bank_word_t val;
      val = ref_mem[w];
      for (int r = 0; r < iccm_pkg::RED_ROWS; r++) begin
         if (row_valid[r] && row_addr[r] == w) val = row_data[r];
      end
      return val;
   endfunction

   //*********************************************************************
   // Reference function giving data over the raw pair
   //*********************************************************************
   function automatic logic [2*(iccm_pkg::DATA_W+iccm_pkg::WORD_W)-1:0] expect_read(
      input logic [8:0] a);                        // Halfword address
      logic [7:0]           lo_w;
      logic [7:0]           hi_w;
      iccm_pkg::bank_word_t lo;
      iccm_pkg::bank_word_t hi;
      logic [63:0]          d;
      lo_w = a[8:1];
      hi_w = a[0] ? lo_w + 8'd1 : lo_w;          // Odd start spills into next word
      lo   = fetch_word(lo_w);
      hi   = fetch_word(hi_w);
      d    = {hi[31:0], lo[31:0]};
      if (a[0]) d = d >> 16;
      return {d, hi, lo};
   endfunction

   task automatic apply_write(input iccm_pkg::iccm_req_t q);
      logic [7:0] w;
      logic       dw;
      w  = q.rw_addr[9:2];
      dw = (q.wr_size[1:0] == 2'b11);
      ref_mem[w] = q.wr_data[w[0]];                  // Even words lane 0
      if (dw) ref_mem[w + 8'd1] = q.wr_data[~w[0]];
      for (int r = 0; r < iccm_pkg::RED_ROWS; r++) begin
         if (row_valid[r] && (row_addr[r] == w || (dw && row_addr[r][7:1] == w[7:1])))
            row_data[r] = q.wr_data[row_addr[r][0]];
      end
   endtask

   always @(negedge clk) begin
      if (!rst_n) begin
         for (int r = 0; r < iccm_pkg::RED_ROWS; r++) row_valid[r] = 1'b0;
         ref_lru     = 1'b0;
         pend        = 1'b0;
         checks      = 0;
         errors      = 0;
         test_checks = 0;
         test_errors = 0;
      end
      else begin
         if (pend) begin                           // Result of last cycle's read
            checks++;
            test_checks++;
            if (rd_data !== exp_data || rd_data_ecc !== exp_ecc) begin
               errors++;
               test_errors++;
               $display("Fail %s: read 0x%03h expected %016h %020h actual %016h %020h",
                        test_label(test_id), {pend_addr, 1'b0}, exp_data, exp_ecc,
                        rd_data, rd_data_ecc);
            end
            pend = 1'b0;
         end
         if (test_end) begin
            $display("Test %s done: %0d checks, %0d errors", test_label(test_id),
                     test_checks, test_errors);
            test_checks = 0;
            test_errors = 0;
         end
         if (req.rden) begin
            {exp_data, exp_ecc} = expect_read(req.rw_addr);
            pend_addr = req.rw_addr;
            pend      = 1'b1;
         end
         if (req.wren) apply_write(req);
         if (buf_correct_ecc) begin                // Fill the LRU row
            row_addr[ref_lru]  = req.rw_addr[9:2];
            row_data[ref_lru]  = req.wr_data[req.rw_addr[2]];
            row_valid[ref_lru] = 1'b1;
            ref_lru            = ~ref_lru;
         end
      end
   end

endmodule

`default_nettype wire

// ==== iccm_mem_tb.sv ====
// Stimulus uses a fixed LFSR seed and the run stops itself at a cycle limit from the test lengths
`timescale 1ns/1ps
`default_nettype none

module iccm_mem_tb;

   logic                 clk;
   logic                 rst_n;
   iccm_pkg::iccm_req_t  req;
   logic                 buf_correct_ecc;
   logic [63:0]          rd_data;
   logic [77:0]          rd_data_ecc;
   logic [2:0]           test_id;
   logic                 test_end;
   int                   checks;
   int                   errors;
   int                   cycles = 0;
   int                   dw_count = 24;      // Double word writes in test 2
   int                   odd_count = 64;     // Odd reads in test 3
   int                   cycle_limit;
   logic [15:0]          lfsr = 16'd11863;

   iccm_mem dut0 (
      .clk             (clk),
      .rst_n           (rst_n),
      .req             (req),
      .buf_correct_ecc (buf_correct_ecc),
      .rd_data         (rd_data),
      .rd_data_ecc     (rd_data_ecc)
   );

   iccm_mem_checker chk0 (
      .clk             (clk),
      .rst_n           (rst_n),
      .req             (req),
      .buf_correct_ecc (buf_correct_ecc),
      .rd_data         (rd_data),
      .rd_data_ecc     (rd_data_ecc),
      .test_id         (test_id),
      .test_end        (test_end),
      .checks          (checks),
      .errors          (errors)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("Run stopped after %0d cycles with tests unfinished", cycles);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   //*********************************************************************
   // Random bits and bus drivers
   //*********************************************************************
   // Galois step for x^16+x^14+x^13+x^11+1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = lfsr[0];                           // One step per bit
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic drive(input logic wr, input logic rd, input logic cap, input logic [8:0] a,
                        input logic [2:0] size, input iccm_pkg::bank_word_t lane1,
                        input iccm_pkg::bank_word_t lane0);
      iccm_pkg::iccm_req_t r;
      r.wren    = wr;
      r.rden    = rd;
      r.rw_addr = a;
      r.wr_size = size;
      r.wr_data = {lane1, lane0};
      @(posedge clk);
      req             <= r;
      buf_correct_ecc <= cap;
   endtask

   task automatic idle();
      drive(1'b0, 1'b0, 1'b0, 9'd0, 3'b010, '0, '0);
   endtask

   task automatic write_word(input logic [7:0] w, input iccm_pkg::bank_word_t d);
      drive(1'b1, 1'b0, 1'b0, {w, 1'b0}, 3'b010, d, d);   // Same word in both lanes
   endtask

   task automatic write_pair(input logic [7:0] w, input iccm_pkg::bank_word_t d0,
                             input iccm_pkg::bank_word_t d1);
      drive(1'b1, 1'b0, 1'b0, {w, 1'b0}, iccm_pkg::SIZE_DW, d1, d0);
   endtask

   task automatic read_half(input logic [8:0] a);
      drive(1'b0, 1'b1, 1'b0, a, 3'b010, '0, '0);
   endtask

   task automatic capture(input logic [7:0] w, input iccm_pkg::bank_word_t d);
      drive(1'b0, 1'b0, 1'b1, {w, 1'b0}, 3'b010, d, d);
   endtask

   task automatic end_test(input logic [2:0] next_id);
      idle();                                      // Last result drains
      @(posedge clk);
      test_end <= 1'b1;
      @(posedge clk);
      test_end <= 1'b0;
      test_id  <= next_id;
   endtask

   //*********************************************************************
   // Tests
   //*********************************************************************
   initial begin
      logic [63:0]          v;
      logic [7:0]           wa;
      iccm_pkg::bank_word_t d0;
      iccm_pkg::bank_word_t d1;
      cycle_limit     = 17 + 515 + 3 * dw_count + 3 + odd_count + 3 + 40 + 100;
      rst_n           = 1'b0;
      req             = '0;
      buf_correct_ecc = 1'b0;
      test_id         = 3'd1;
      test_end        = 1'b0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      for (int w = 0; w < 256; w++) begin          // Fill every word
         rand_bits(39, v);
         write_word(w[7:0], v[38:0]);
      end
      for (int w = 0; w < 256; w++) read_half({w[7:0], 1'b0});
      end_test(3'd2);

      for (int k = 0; k < dw_count; k++) begin
         rand_bits(8, v);
         wa = v[7:0];
         if (k % 4 == 0) wa[1:0] = 2'b11;          // Bank 3 into bank 0
         if (k == 1) wa = 8'hFF;                   // Top word wraps to word 0
         rand_bits(39, v);
         d0 = v[38:0];
         rand_bits(39, v);
         d1 = v[38:0];
         write_pair(wa, d0, d1);
         read_half({wa, 1'b0});
         read_half({wa + 8'd1, 1'b0});
      end
      end_test(3'd3);

      for (int k = 0; k < odd_count; k++) begin    // Back to back
         rand_bits(8, v);
         read_half({(k == 0) ? 8'hFF : v[7:0], 1'b1});
      end
      end_test(3'd4);

      rand_bits(39, v);
      write_word(8'h21, v[38:0]);
      rand_bits(39, v);
      capture(8'h21, v[38:0]);                     // Row 0
      read_half({8'h21, 1'b0});
      read_half({8'h20, 1'b1});
      rand_bits(39, v);
      capture(8'h5A, v[38:0]);                     // Row 1
      read_half({8'h5A, 1'b0});
      read_half({8'h21, 1'b0});
      rand_bits(39, v);
      capture(8'h94, v[38:0]);                     // Evicts 0x21 from row 0
      read_half({8'h21, 1'b0});
      read_half({8'h94, 1'b0});
      read_half({8'h59, 1'b1});
      end_test(3'd5);

      rand_bits(39, v);
      write_word(8'h5A, v[38:0]);
      read_half({8'h5A, 1'b0});
      rand_bits(39, v);
      d0 = v[38:0];
      rand_bits(39, v);
      write_pair(8'h94, d0, v[38:0]);
      read_half({8'h94, 1'b0});
      read_half({8'h94, 1'b1});
      read_half({8'h95, 1'b0});
      end_test(3'd0);

      @(posedge clk);
      $display("Totals: 5 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("NO ERRORS");
      end
      else begin
         if (checks == 0) $display("No read results were compared");
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== iccm_pkg.sv ====
// Sizes are fixed for a 1 KiB ICCM in four banks and the check bits are carried but never computed
`default_nettype none

package iccm_pkg;

   //*********************************************************************
   // Geometry
   //*********************************************************************
   localparam int ICCM_BITS  = 10;            // Byte address width
   localparam int NUM_BANKS  = 4;
   localparam int BANK_HI    = 3;             // Bank select is bits 3..2
   localparam int INDEX_LO   = 4;             // Row index starts above the bank bits
   localparam int INDEX_BITS = 6;             // 64 rows per bank
   localparam int WORD_W     = 39;            // 32 data + 7 check
   localparam int DATA_W     = 32;
   localparam int RED_ROWS   = 2;             // Spare rows for hard faults

   localparam logic [2:0] SIZE_DW = 3'b011;   // Double word write

   //*********************************************************************
   // Types
   //*********************************************************************
   typedef logic [ICCM_BITS-1:1] iccm_addr_t; // Halfword address
   typedef logic [ICCM_BITS-1:2] word_addr_t; // Word address
   typedef logic [WORD_W-1:0]    bank_word_t;

   typedef struct packed {
      logic                 wren;
      logic                 rden;
      iccm_addr_t           rw_addr;
      logic [2:0]           wr_size;
      bank_word_t [1:0]     wr_data;          // Lane 1 on top
   } iccm_req_t;

   typedef struct packed {
      logic                  en;
      logic                  we;
      logic [INDEX_BITS-1:0] index;
      bank_word_t            wdata;
   } bank_req_t;

   // Which bank read gets replaced by which spare row
   typedef struct packed {
      logic [NUM_BANKS-1:0] sel0;
      logic [NUM_BANKS-1:0] sel1;
   } red_sel_t;

   //*********************************************************************
   // Helpers
   //*********************************************************************
   function automatic word_addr_t word_addr(input iccm_addr_t a);
      return a[ICCM_BITS-1:2];
   endfunction

   // One bit per bank, set for the bank holding this address
   function automatic logic [NUM_BANKS-1:0] bank_onehot(input iccm_addr_t a);
      logic [NUM_BANKS-1:0] oh;
      oh = '0;
      oh[a[BANK_HI:2]] = 1'b1;
      return oh;
   endfunction

   function automatic logic is_dw(input logic [2:0] size);
      return size[1:0] == SIZE_DW[1:0];      // Upper size bit ignored
   endfunction

endpackage

`default_nettype wire

// ==== iccm_read_align.sv ====
// Read result follows the bank outputs one cycle after rden and the upper halfword is zero when odd
`timescale 1ns/1ps
`default_nettype none

module iccm_read_align (
   input  wire logic                                          clk,
   input  wire logic                                          rst_n,
   input  wire iccm_pkg::iccm_req_t                           req,
   input  wire iccm_pkg::iccm_addr_t                          inc_addr,
   input  wire iccm_pkg::bank_word_t [iccm_pkg::NUM_BANKS-1:0] dout_fn,
   output logic [2*iccm_pkg::DATA_W-1:0]                      rd_data,
   output logic [2*iccm_pkg::WORD_W-1:0]                      rd_data_ecc
);

   logic [iccm_pkg::BANK_HI:1]    rd_lo_q;   // Bank and halfword of rw_addr
   logic [iccm_pkg::BANK_HI:2]    rd_hi_q;   // Bank of inc_addr
   iccm_pkg::bank_word_t          lo_word;
   iccm_pkg::bank_word_t          hi_word;
   logic [2*iccm_pkg::DATA_W-1:0] data_pre;

   //*********************************************************************
   // Address capture
   //*********************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_lo_q <= '0;
         rd_hi_q <= '0;
      end
      else if (req.rden) begin
         rd_lo_q <= req.rw_addr[iccm_pkg::BANK_HI:1];
         rd_hi_q <= inc_addr[iccm_pkg::BANK_HI:2];
      end
   end

   //*********************************************************************
   // Word pick and halfword shift
   //*********************************************************************
   assign lo_word = dout_fn[rd_lo_q[iccm_pkg::BANK_HI:2]];
   assign hi_word = dout_fn[rd_hi_q];

   assign rd_data_ecc = {hi_word, lo_word};       // Raw pair, check bits kept
   assign data_pre    = {hi_word[iccm_pkg::DATA_W-1:0], lo_word[iccm_pkg::DATA_W-1:0]};

   // Odd halfword start drops the lowest 16 bits
   assign rd_data = rd_lo_q[1] ? {{(iccm_pkg::DATA_W/2){1'b0}},
                                  data_pre[2*iccm_pkg::DATA_W-1:iccm_pkg::DATA_W/2]} :
                                 data_pre;

endmodule

`default_nettype wire

// ==== iccm_redundancy.sv ====
// Two spare rows replaced by LRU on each correction strobe and never loaded twice with one address
`timescale 1ns/1ps
`default_nettype none

module iccm_redundancy (
   input  wire logic                                        clk,
   input  wire logic                                        rst_n,
   input  wire iccm_pkg::iccm_req_t                         req,
   input  wire iccm_pkg::iccm_addr_t                        inc_addr,
   input  wire logic                                        buf_correct_ecc,  // Capture strobe
   input  wire iccm_pkg::bank_word_t [iccm_pkg::NUM_BANKS-1:0] bank_dout,
   output iccm_pkg::bank_word_t [iccm_pkg::NUM_BANKS-1:0]   dout_fn           // After substitution
);

   // Spare row state
   iccm_pkg::word_addr_t [iccm_pkg::RED_ROWS-1:0] red_addr;
   iccm_pkg::bank_word_t [iccm_pkg::RED_ROWS-1:0] red_data;
   logic [iccm_pkg::RED_ROWS-1:0]                 red_valid;
   logic                                          lru;       // Row to fill next

   logic [iccm_pkg::RED_ROWS-1:0][iccm_pkg::NUM_BANKS-1:0] row_hit;
   logic [iccm_pkg::NUM_BANKS-1:0] lo_hit;
   logic [iccm_pkg::NUM_BANKS-1:0] hi_hit;
   iccm_pkg::word_addr_t           lo_wa;
   iccm_pkg::word_addr_t           hi_wa;
   iccm_pkg::red_sel_t             sel;
   iccm_pkg::red_sel_t             sel_q;

   assign lo_wa  = iccm_pkg::word_addr(req.rw_addr);
   assign hi_wa  = iccm_pkg::word_addr(inc_addr);
   assign lo_hit = iccm_pkg::bank_onehot(req.rw_addr);
   assign hi_hit = iccm_pkg::bank_onehot(inc_addr);

   //*********************************************************************
   // Spare rows
   //*********************************************************************
   for (genvar r = 0; r < iccm_pkg::RED_ROWS; r++) begin : g_row
      logic               cap_en;   // Correction into this row
      logic               upd_en;   // Write hitting this row
      iccm_pkg::bank_word_t data_in;

      assign cap_en = buf_correct_ecc & (lru == 1'(r));
      assign upd_en = red_valid[r] & req.wren &
                      ((lo_wa == red_addr[r]) |
                       (iccm_pkg::is_dw(req.wr_size) &
                        (lo_wa[iccm_pkg::ICCM_BITS-1:3] == red_addr[r][iccm_pkg::ICCM_BITS-1:3])));

      // Lane picked by the incoming address on capture, else by the row's own bit 2
      assign data_in = cap_en ? req.wr_data[req.rw_addr[2]] : req.wr_data[red_addr[r][2]];

      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            red_valid[r] <= 1'b0;
         end
         else if (cap_en) begin
            red_valid[r] <= 1'b1;
         end
      end

      always_ff @(posedge clk) begin
         if (cap_en) red_addr[r] <= lo_wa;
         if (cap_en | upd_en) red_data[r] <= data_in;
      end

      // Banks whose read this row replaces
      assign row_hit[r] = {iccm_pkg::NUM_BANKS{red_valid[r]}} &
                          ((lo_hit & {iccm_pkg::NUM_BANKS{lo_wa == red_addr[r]}}) |
                           (hi_hit & {iccm_pkg::NUM_BANKS{hi_wa == red_addr[r]}}));
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lru <= 1'b0;
      end
      else if (buf_correct_ecc) begin
         lru <= ~lru;                  // Alternate between rows
      end
   end

   //*********************************************************************
   // Read substitution
   //*********************************************************************
   assign sel.sel0 = row_hit[0];
   assign sel.sel1 = row_hit[1];

   // Held with the bank output until the next read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sel_q <= '0;
      end
      else if (req.rden) begin
         sel_q <= sel;
      end
   end

   for (genvar i = 0; i < iccm_pkg::NUM_BANKS; i++) begin : g_mux
      assign dout_fn[i] = sel_q.sel1[i] ? red_data[1] :
                          sel_q.sel0[i] ? red_data[0] :
                                          bank_dout[i];
   end

   //*********************************************************************
   // Checks
   //*********************************************************************
   a_no_cap_on_read : assert property (@(posedge clk) disable iff (!rst_n)
      !(buf_correct_ecc && req.rden))
      else $error("Correction strobe during a read");

   // Both rows holding one word means a repeated capture
   a_one_row_per_bank : assert property (@(posedge clk) disable iff (!rst_n)
      (sel_q.sel0 & sel_q.sel1) == '0)
      else $error("Two spare rows selected for one bank");

endmodule

`default_nettype wire
